//--- adc_acq.f
logic/adc_acq_pkg.sv
logic/adc_acq_sequencer.sv
logic/adc_circ_buf.sv
logic/adc_acq_counters.sv
logic/adc_record_mux.sv
logic/adc_acq_top.sv
testbench/adc_acq_properties.sv
testbench/adc_acq_tb.sv

//--- logic/adc_acq_counters.sv
module adc_acq_counters #(
    parameter int buf_addr_w = 8,
    parameter int adr_w = 16,
    parameter int burst_count_1 = 2,
    parameter int burst_count_2 = 5,
    parameter int burst_count_3 = 8
) (
    input  logic                                clk,
    input  logic                                adc_acq_full_reset,
    input  logic [adc_acq_pkg::fill_type_w-1:0] fill_type,
    input  logic                                burst_cntr_init,
    input  logic                                burst_cntr_en,
    input  logic                                fill_cntr_en,
    input  logic                                address_cntr_en,
    output logic [buf_addr_w-1:0]               burst_count,
    output logic                                burst_cntr_zero,
    output logic [adr_w-1:0]                    fill_count,
    output logic [adr_w-1:0]                    wb_adr
);

    logic [buf_addr_w-1:0] burst_load;

    // type 0 never starts a fill, so it shares the type 1 count
    always_comb begin
        case (fill_type)
            2'd2: burst_load = buf_addr_w'(burst_count_2);
            2'd3: burst_load = buf_addr_w'(burst_count_3);
            default: burst_load = buf_addr_w'(burst_count_1);
        endcase
    end

    // bursts left in this fill, held at zero once spent
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            burst_count <= '0;
        end else if (burst_cntr_init) begin
            burst_count <= burst_load;
        end else if (burst_cntr_en && !burst_cntr_zero) begin
            burst_count <= burst_count - 1'b1;
        end
    end

    assign burst_cntr_zero = (burst_count == '0);

    // completed fills and record address, both run across fills
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            fill_count <= '0;
            wb_adr <= '0;
        end else begin
            if (fill_cntr_en) fill_count <= fill_count + 1'b1;
            if (address_cntr_en) wb_adr <= wb_adr + 1'b1;
        end
    end

endmodule

//--- logic/adc_acq_pkg.sv
package adc_acq_pkg;

    // one adc word carries two samples, each right aligned in its 16-bit half
    // sample 0 sits in bits 11:0 and sample 1 in bits 27:16
    localparam int sample_w = 12;
    localparam int word_w = 32;

    // data records hold this many buffer words
    localparam int words_per_burst = 4;

    // four 32-bit lanes per record, lane 0 in the low bits
    // lane 3 carries the tag of header and checksum records
    localparam int rec_w = 128;

    // 0 = disarmed, 1..3 pick a burst count
    localparam int fill_type_w = 2;

    // record tags for lane 3
    localparam logic [word_w-1:0] fill_hdr_tag = 32'hadc0_f111;
    localparam logic [word_w-1:0] wfm_hdr_tag = 32'hadc0_3a7e;
    localparam logic [word_w-1:0] csum_tag = 32'hadc0_c5c5;

endpackage

//--- logic/adc_acq_sequencer.sv
module adc_acq_sequencer (
    input  logic                                clk,
    input  logic                                adc_acq_full_reset,
    input  logic                                acq_enable0,
    input  logic                                acq_enable1,
    input  logic                                acq_trig,
    input  logic                                burst_cntr_zero,
    input  logic                                wb_ack,
    output logic [adc_acq_pkg::fill_type_w-1:0] fill_type,
    output logic                                trig_capture,
    output logic                                init_rd_addr,
    output logic                                inc_rd_addr,
    output logic                                latch_word,
    output logic                                fill_hdr_sel,
    output logic                                wfm_hdr_sel,
    output logic                                dat_sel,
    output logic                                checksum_sel,
    output logic                                checksum_clear,
    output logic                                checksum_update,
    output logic                                burst_cntr_init,
    output logic                                burst_cntr_en,
    output logic                                fill_cntr_en,
    output logic                                address_cntr_en,
    output logic                                wb_cyc,
    output logic                                wb_stb,
    output logic                                wb_we,
    output logic                                acq_enabled,
    output logic                                acq_done,
    output logic                                sm_idle
);

    // one-hot state bit positions
    localparam int s_idle = 0;
    localparam int s_watch = 1;
    localparam int s_fill_init = 2;
    localparam int s_wfm_init = 3;
    localparam int s_run1 = 4;
    localparam int s_run2 = 5;
    localparam int s_run3 = 6;
    localparam int s_run4 = 7;
    localparam int s_wfm_tst = 8;
    localparam int s_checksum = 9;
    localparam int s_done = 10;
    localparam int n_states = 11;

    logic [3:0] enable0_sync;
    logic [3:0] enable1_sync;
    logic [3:0] trig_sync;
    logic armed;
    logic ack_ok;
    logic run_entry;
    logic [n_states-1:0] cs;
    logic [n_states-1:0] ns;
    logic [n_states-1:0] enter;

    // four flop synchronizers, oldest sample in bit 3
    always_ff @(posedge clk) begin
        enable0_sync <= {enable0_sync[2:0], acq_enable0};
        enable1_sync <= {enable1_sync[2:0], acq_enable1};
        trig_sync <= {trig_sync[2:0], acq_trig};
    end

    // the enable pair is both the arm bit and the fill type
    assign fill_type = {enable1_sync[3], enable0_sync[3]};
    assign armed = |fill_type;

    // record accepted by the slave this cycle
    assign ack_ok = wb_cyc & wb_ack;

    // a state bit rising marks entry, so waiting states strobe only once
    assign enter = ns & ~cs;
    assign run_entry = enter[s_run1] | enter[s_run2] | enter[s_run3] | enter[s_run4];

    // single write cycles only
    assign wb_stb = wb_cyc;
    assign wb_we = wb_cyc;

    always_comb begin
        ns = '0;
        case (1'b1)
            cs[s_idle]: begin
                if (armed) ns[s_watch] = 1'b1;
                else ns[s_idle] = 1'b1;
            end
            // stays here as long as armed, so trigger latency is fixed
            cs[s_watch]: begin
                if (!armed) ns[s_idle] = 1'b1;
                else if (trig_sync[3]) ns[s_fill_init] = 1'b1;
                else ns[s_watch] = 1'b1;
            end
            // fill header record
            cs[s_fill_init]: begin
                if (ack_ok) ns[s_wfm_init] = 1'b1;
                else ns[s_fill_init] = 1'b1;
            end
            // waveform header record
            cs[s_wfm_init]: begin
                if (ack_ok) ns[s_run1] = 1'b1;
                else ns[s_run1 - 1] = 1'b1;
            end
            // one buffer word per run state
            cs[s_run1]: ns[s_run2] = 1'b1;
            cs[s_run2]: ns[s_run3] = 1'b1;
            cs[s_run3]: ns[s_run4] = 1'b1;
            // data record, then either another burst or the checksum
            cs[s_run4]: begin
                if (!ack_ok) ns[s_run4] = 1'b1;
                else if (burst_cntr_zero) ns[s_wfm_tst] = 1'b1;
                else ns[s_run1] = 1'b1;
            end
            // checksum record is presented here
            cs[s_wfm_tst]: ns[s_checksum] = 1'b1;
            cs[s_checksum]: begin
                if (ack_ok) ns[s_done] = 1'b1;
                else ns[s_checksum] = 1'b1;
            end
            // hold off retrigger until the trigger drops or we are disarmed
            cs[s_done]: begin
                if (armed && trig_sync[3]) ns[s_done] = 1'b1;
                else ns[s_idle] = 1'b1;
            end
            default: ns[s_idle] = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            cs <= '0;
            cs[s_idle] <= 1'b1;
            trig_capture <= 1'b0;
            init_rd_addr <= 1'b0;
            inc_rd_addr <= 1'b0;
            latch_word <= 1'b0;
            fill_hdr_sel <= 1'b0;
            wfm_hdr_sel <= 1'b0;
            dat_sel <= 1'b0;
            checksum_sel <= 1'b0;
            checksum_clear <= 1'b0;
            checksum_update <= 1'b0;
            burst_cntr_init <= 1'b0;
            burst_cntr_en <= 1'b0;
            fill_cntr_en <= 1'b0;
            address_cntr_en <= 1'b0;
            wb_cyc <= 1'b0;
            acq_enabled <= 1'b0;
            acq_done <= 1'b0;
            sm_idle <= 1'b1;
        end else begin
            cs <= ns;
            // new fill: grab the trigger point, build the fill header
            trig_capture <= enter[s_fill_init];
            fill_hdr_sel <= enter[s_fill_init];
            checksum_clear <= enter[s_fill_init];
            burst_cntr_init <= enter[s_fill_init];
            // waveform header and read pointer load
            wfm_hdr_sel <= enter[s_wfm_init];
            init_rd_addr <= enter[s_wfm_init];
            // each run state takes one word and steps the read pointer
            latch_word <= run_entry;
            inc_rd_addr <= run_entry;
            checksum_update <= run_entry;
            // one count per burst
            burst_cntr_en <= enter[s_run1];
            dat_sel <= enter[s_run4];
            checksum_sel <= enter[s_wfm_tst];
            // record address steps on every ack, fill count after the checksum
            address_cntr_en <= ack_ok;
            fill_cntr_en <= ack_ok & cs[s_checksum];
            // cycle opens once the selected record is on wb_dat
            if (fill_hdr_sel | wfm_hdr_sel | dat_sel | checksum_sel) begin
                wb_cyc <= 1'b1;
            end else if (ack_ok) begin
                wb_cyc <= 1'b0;
            end
            acq_enabled <= !(ns[s_idle] || ns[s_watch]);
            acq_done <= ns[s_done];
            sm_idle <= ns[s_idle];
        end
    end

endmodule

//--- logic/adc_acq_top.sv
module adc_acq_top #(
    parameter int buf_addr_w = 8,
    parameter int pretrig_words = 16,
    parameter int burst_count_1 = 2,
    parameter int burst_count_2 = 5,
    parameter int burst_count_3 = 8,
    parameter int adr_w = 16
) (
    input  logic                            clk,
    input  logic                            adc_acq_full_reset,
    input  logic [adc_acq_pkg::word_w-1:0]  sample_word,
    input  logic                            acq_enable0,
    input  logic                            acq_enable1,
    input  logic                            acq_trig,
    input  logic                            wb_ack,
    output logic                            wb_cyc,
    output logic                            wb_stb,
    output logic                            wb_we,
    output logic [adr_w-1:0]                wb_adr,
    output logic [adc_acq_pkg::rec_w-1:0]   wb_dat,
    output logic                            acq_enabled,
    output logic                            acq_done,
    output logic                            sm_idle
);

    // sequencer strobes into the datapath
    logic [adc_acq_pkg::fill_type_w-1:0] fill_type;
    logic trig_capture;
    logic init_rd_addr;
    logic inc_rd_addr;
    logic latch_word;
    logic fill_hdr_sel;
    logic wfm_hdr_sel;
    logic dat_sel;
    logic checksum_sel;
    logic checksum_clear;
    logic checksum_update;
    logic burst_cntr_init;
    logic burst_cntr_en;
    logic fill_cntr_en;
    logic address_cntr_en;

    // datapath results
    logic burst_cntr_zero;
    logic [buf_addr_w-1:0] start_addr;
    logic [buf_addr_w-1:0] burst_count;
    logic [adr_w-1:0] fill_count;
    logic [adc_acq_pkg::word_w-1:0] rd_word;

    // every port below shares its name with the net it connects to
    adc_acq_sequencer u_sequencer (.*);

    adc_circ_buf #(
        .buf_addr_w    (buf_addr_w),
        .pretrig_words (pretrig_words)
    ) u_circ_buf (.*);

    adc_acq_counters #(
        .buf_addr_w    (buf_addr_w),
        .adr_w         (adr_w),
        .burst_count_1 (burst_count_1),
        .burst_count_2 (burst_count_2),
        .burst_count_3 (burst_count_3)
    ) u_counters (.*);

    adc_record_mux #(
        .buf_addr_w (buf_addr_w),
        .adr_w      (adr_w)
    ) u_record_mux (.*);

endmodule

//--- logic/adc_circ_buf.sv
module adc_circ_buf #(
    parameter int buf_addr_w = 8,
    parameter int pretrig_words = 16
) (
    input  logic                            clk,
    input  logic                            adc_acq_full_reset,
    input  logic [adc_acq_pkg::word_w-1:0]  sample_word,
    input  logic                            trig_capture,
    input  logic                            init_rd_addr,
    input  logic                            inc_rd_addr,
    output logic [buf_addr_w-1:0]           start_addr,
    output logic [adc_acq_pkg::word_w-1:0]  rd_word
);

    localparam int depth = 2 ** buf_addr_w;

    logic [adc_acq_pkg::word_w-1:0] mem [0:depth-1];
    logic [buf_addr_w-1:0] wr_ptr;
    logic [buf_addr_w-1:0] rd_ptr;
    logic [buf_addr_w-1:0] rd_ptr_next;

    // free running write pointer, wraps at the buffer depth
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            wr_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // every adc word is stored, armed or not
    always_ff @(posedge clk) begin
        mem[wr_ptr] <= sample_word;
    end

    // trigger point is the word written on the edge that entered fill init
    // i.e. one behind the pointer seen while the strobe is high
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            start_addr <= '0;
        end else if (trig_capture) begin
            start_addr <= wr_ptr - buf_addr_w'(pretrig_words + 1);
        end
    end

    always_comb begin
        rd_ptr_next = rd_ptr;
        if (init_rd_addr) begin
            rd_ptr_next = start_addr;
        end else if (inc_rd_addr) begin
            rd_ptr_next = rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            rd_ptr <= '0;
        end else begin
            rd_ptr <= rd_ptr_next;
        end
    end

    // read from the next pointer so rd_word always matches rd_ptr
    always_ff @(posedge clk) begin
        rd_word <= mem[rd_ptr_next];
    end

endmodule

//--- logic/adc_record_mux.sv
module adc_record_mux #(
    parameter int buf_addr_w = 8,
    parameter int adr_w = 16
) (
    input  logic                                clk,
    input  logic                                adc_acq_full_reset,
    input  logic [adc_acq_pkg::fill_type_w-1:0] fill_type,
    input  logic [adr_w-1:0]                    fill_count,
    input  logic [buf_addr_w-1:0]               start_addr,
    input  logic [buf_addr_w-1:0]               burst_count,
    input  logic [adc_acq_pkg::word_w-1:0]      rd_word,
    input  logic                                latch_word,
    input  logic                                fill_hdr_sel,
    input  logic                                wfm_hdr_sel,
    input  logic                                dat_sel,
    input  logic                                checksum_sel,
    input  logic                                checksum_clear,
    input  logic                                checksum_update,
    output logic [adc_acq_pkg::rec_w-1:0]       wb_dat
);

    localparam int lane_w = adc_acq_pkg::word_w;
    localparam int burst_w = adc_acq_pkg::words_per_burst * lane_w;
    localparam logic [lane_w-1:0] zero_lane = '0;

    logic [burst_w-1:0] burst_reg;
    logic [burst_w-1:0] burst_next;
    logic [lane_w-1:0] checksum;

    // newest word enters the top lane and shifts down,
    // so after four latches word k sits in lane k
    always_comb begin
        burst_next = burst_reg;
        if (latch_word) begin
            burst_next = {rd_word, burst_reg[burst_w-1:lane_w]};
        end
    end

    always_ff @(posedge clk) begin
        burst_reg <= burst_next;
    end

    // 32-bit wrap-around sum of the data words of one fill
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset || checksum_clear) begin
            checksum <= '0;
        end else if (checksum_update) begin
            checksum <= checksum + rd_word;
        end
    end

    // record lanes from 3 down to 0
    always_ff @(posedge clk) begin
        if (fill_hdr_sel) begin
            wb_dat <= {adc_acq_pkg::fill_hdr_tag, lane_w'(fill_count),
                       lane_w'(fill_type), zero_lane};
        end else if (wfm_hdr_sel) begin
            wb_dat <= {adc_acq_pkg::wfm_hdr_tag, lane_w'(start_addr),
                       lane_w'(burst_count), zero_lane};
        end else if (dat_sel) begin
            // burst_next so the fourth word latched this cycle is included
            wb_dat <= burst_next;
        end else if (checksum_sel) begin
            wb_dat <= {adc_acq_pkg::csum_tag, zero_lane, zero_lane, checksum};
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module adc_acq_tb -f adc_acq.f
output=$(./obj_dir/Vadc_acq_tb 2>&1) || true
echo "$output"
echo "$output" | grep -q "TEST PASSED"

//--- testbench/adc_acq_properties.sv
module adc_acq_properties #(
    parameter int adr_w = 16
) (
    input logic                          clk,
    input logic                          adc_acq_full_reset,
    input logic                          wb_cyc,
    input logic                          wb_stb,
    input logic                          wb_ack,
    input logic [adr_w-1:0]              wb_adr,
    input logic [adc_acq_pkg::rec_w-1:0] wb_dat,
    input logic                          acq_enabled,
    input logic                          acq_done,
    input logic                          sm_idle
);

    // strobe only inside a bus cycle
    stb_inside_cyc: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // a waiting request keeps its address and data until acked
    request_held: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat))
        else $error("wishbone request changed before ack");

    // done only after the last record has been accepted
    done_outside_cycle: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        !(acq_done && wb_cyc))
        else $error("acq_done high during a wishbone cycle");

    quiet_after_reset: assert property (@(posedge clk)
        adc_acq_full_reset |=> !wb_cyc && !wb_stb && !acq_done && !acq_enabled && sm_idle)
        else $error("outputs not in their reset state");

endmodule

//--- testbench/adc_acq_tb.sv
module adc_acq_tb;

    localparam int buf_addr_w = 8;
    localparam int depth = 2 ** buf_addr_w;
    localparam int pretrig_words = 16;
    localparam int burst_count_1 = 2;
    localparam int burst_count_2 = 5;
    localparam int burst_count_3 = 8;
    localparam int adr_w = 16;
    localparam int rec_w = adc_acq_pkg::rec_w;
    localparam int n_fills = 6;
    // six fills of at most eleven records plus idle gaps, with wide margin
    localparam int timeout_cycles = 20000;
    localparam logic [31:0] seed = 32'd30;

    logic clk;
    logic adc_acq_full_reset = 1'b1;
    logic [adc_acq_pkg::word_w-1:0] sample_word = '0;
    logic acq_enable0 = 1'b0;
    logic acq_enable1 = 1'b0;
    logic acq_trig = 1'b0;
    logic wb_ack = 1'b0;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [adr_w-1:0] wb_adr;
    logic [rec_w-1:0] wb_dat;
    logic acq_enabled;
    logic acq_done;
    logic sm_idle;

    // model of the circular buffer, indexed like the dut write pointer
    logic [31:0] model_mem [0:depth-1];
    logic [31:0] word_rng = seed;
    logic [31:0] ack_rng = seed ^ 32'h0000_a5a5;
    logic [31:0] ctrl_rng = seed ^ 32'h5a5a_0000;
    logic [adc_acq_pkg::sample_w-1:0] sample_a;
    logic [adc_acq_pkg::sample_w-1:0] sample_b;
    logic [31:0] new_word;
    int wr_count = 0;
    int next_ptr;
    int cycle_count = 0;
    int ack_wait = -1;
    int rec_in_fill = 0;
    int rec_total = 0;
    int fills_checked = 0;
    int triggers_sent = 0;
    int total_expected = 0;
    // fields of the fill in flight
    int exp_ft = 1;
    int exp_n = 0;
    int exp_start = 0;
    int exp_fill = 0;

    adc_acq_top #(
        .buf_addr_w    (buf_addr_w),
        .pretrig_words (pretrig_words),
        .burst_count_1 (burst_count_1),
        .burst_count_2 (burst_count_2),
        .burst_count_3 (burst_count_3),
        .adr_w         (adr_w)
    ) dut (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .sample_word        (sample_word),
        .acq_enable0        (acq_enable0),
        .acq_enable1        (acq_enable1),
        .acq_trig           (acq_trig),
        .wb_ack             (wb_ack),
        .wb_cyc             (wb_cyc),
        .wb_stb             (wb_stb),
        .wb_we              (wb_we),
        .wb_adr             (wb_adr),
        .wb_dat             (wb_dat),
        .acq_enabled        (acq_enabled),
        .acq_done           (acq_done),
        .sm_idle            (sm_idle)
    );

    bind adc_acq_top adc_acq_properties #(
        .adr_w (adr_w)
    ) u_properties (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .wb_cyc             (wb_cyc),
        .wb_stb             (wb_stb),
        .wb_ack             (wb_ack),
        .wb_adr             (wb_adr),
        .wb_dat             (wb_dat),
        .acq_enabled        (acq_enabled),
        .acq_done           (acq_done),
        .sm_idle            (sm_idle)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int bursts_for_type(input int ft);
        case (ft)
            1: return burst_count_1;
            2: return burst_count_2;
            default: return burst_count_3;
        endcase
    endfunction

    // truncation gives the wrap at the buffer depth
    function automatic logic [buf_addr_w-1:0] buf_index(input int p);
        return buf_addr_w'(p);
    endfunction

    function automatic string record_name(input int r);
        if (r == 0) return "fill header";
        if (r == 1) return "waveform header";
        if (r < exp_n + 2) return "data record";
        return "checksum record";
    endfunction

    // record r of the fill in flight, built from the model buffer
    function automatic logic [rec_w-1:0] expected_record(input int r);
        logic [rec_w-1:0] rec;
        logic [31:0] sum;
        int base;
        int lane;
        int k;
        rec = '0;
        sum = '0;
        if (r == 0) begin
            rec = {adc_acq_pkg::fill_hdr_tag, 32'(exp_fill), 32'(exp_ft), 32'h0};
        end else if (r == 1) begin
            rec = {adc_acq_pkg::wfm_hdr_tag, 32'(exp_start), 32'(exp_n), 32'h0};
        end else if (r < exp_n + 2) begin
            // word k of the waveform in lane k mod 4
            base = adc_acq_pkg::words_per_burst * (r - 2);
            for (lane = 0; lane < adc_acq_pkg::words_per_burst; lane++) begin
                rec[lane*32 +: 32] = model_mem[buf_index(exp_start + base + lane)];
            end
        end else begin
            for (k = 0; k < adc_acq_pkg::words_per_burst * exp_n; k++) begin
                sum = sum + model_mem[buf_index(exp_start + k)];
            end
            rec = {adc_acq_pkg::csum_tag, 32'h0, 32'h0, sum};
        end
        return rec;
    endfunction

    task automatic report_mismatch(input string field, input logic [rec_w-1:0] got,
                                   input logic [rec_w-1:0] exp);
        $display("FAIL t=%0t %s: got %h expected %h", $time, field, got, exp);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_error(input string msg);
        $display("%s, at time %0t", msg, $time);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_record();
        logic [rec_w-1:0] exp_rec;
        assert (triggers_sent > fills_checked)
            else report_error("record written while no fill was triggered");
        assert (wb_we) else report_error("write enable low during a record write");
        assert (acq_enabled) else report_error("acq_enabled low during a record write");
        assert (wb_adr == adr_w'(rec_total))
            else report_mismatch("wb_adr", rec_w'(wb_adr), rec_w'(rec_total));
        exp_rec = expected_record(rec_in_fill);
        assert (wb_dat === exp_rec)
            else report_mismatch(record_name(rec_in_fill), wb_dat, exp_rec);
        rec_total++;
        rec_in_fill++;
        // checksum closes the fill
        if (rec_in_fill == exp_n + 3) begin
            rec_in_fill = 0;
            fills_checked <= fills_checked + 1;
        end
    endtask

    // adc words, buffer model, wishbone slave and timeout
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("TEST FAILED");
            $fatal(1, "stopping on timeout");
        end
        word_rng = lcg_next(word_rng);
        sample_a = word_rng[31:20];
        sample_b = word_rng[19:8];
        new_word = {4'h0, sample_b, 4'h0, sample_a};
        sample_word <= new_word;
        // mirror of wr_ptr, the word driven now lands at the new pointer
        next_ptr = adc_acq_full_reset ? 0 : wr_count + 1;
        model_mem[buf_index(next_ptr)] = new_word;
        wr_count <= next_ptr;
        // one ack per request after 0 to 3 wait cycles
        if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (ack_wait < 0) begin
                ack_rng = lcg_next(ack_rng);
                ack_wait = int'(ack_rng[31:30]);
            end
            if (ack_wait == 0) begin
                check_record();
                wb_ack <= 1'b1;
                ack_wait = -1;
            end else begin
                ack_wait--;
            end
        end
    end

    task automatic hold_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            assert (sm_idle && !wb_cyc && !acq_done && !acq_enabled)
                else report_error("subsystem left idle while disarmed");
        end
    endtask

    task automatic run_fill(input int idx);
        int ft;
        int gap;
        logic [adc_acq_pkg::fill_type_w-1:0] code;
        ctrl_rng = lcg_next(ctrl_rng);
        ft = 1 + int'(ctrl_rng[31:16] % 16'd3);
        gap = 2 + int'(ctrl_rng[15:12]);
        code = adc_acq_pkg::fill_type_w'(ft);
        @(posedge clk);
        acq_enable0 <= code[0];
        acq_enable1 <= code[1];
        repeat (gap) @(posedge clk);
        exp_ft = ft;
        exp_n = bursts_for_type(ft);
        exp_fill = idx;
        // trigger point is the write pointer five edges on
        exp_start = (wr_count + 5 - pretrig_words) % depth;
        total_expected += exp_n + 3;
        acq_trig <= 1'b1;
        triggers_sent <= triggers_sent + 1;
        while (fills_checked == idx) @(posedge clk);
        @(posedge clk);
        // trigger still high, so done must hold with the bus quiet
        repeat (6) begin
            assert (acq_done && !wb_cyc)
                else report_error("acq_done dropped or a record appeared after the fill");
            @(posedge clk);
        end
        acq_enable0 <= 1'b0;
        acq_enable1 <= 1'b0;
        acq_trig <= 1'b0;
        // synchronizer delay before idle
        repeat (8) @(posedge clk);
        hold_idle(10);
    endtask

    initial begin
        int fill_idx;
        repeat (16) @(posedge clk);
        adc_acq_full_reset <= 1'b0;
        // let the buffer fill once before the first trigger
        hold_idle(depth + 8);
        for (fill_idx = 0; fill_idx < n_fills; fill_idx++) begin
            run_fill(fill_idx);
        end
        // address has stepped past the last checksum record
        assert (wb_adr == adr_w'(total_expected))
            else report_mismatch("final wb_adr", rec_w'(wb_adr), rec_w'(total_expected));
        $display("TEST PASSED");
        $finish;
    end

endmodule
